/* rtl/hawk_pkg.sv */
`default_nettype none

package hawk_pkg;

    // AXI widths seen on both the CPU and the memory side
    localparam int ADDR_W = 40;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W = 4;
    localparam int LEN_W = 8;

    // 4 KB pages
    localparam int PAGE_LSB = 12;
    localparam int PAGE_W = ADDR_W - PAGE_LSB;

    // Burst storage, one entry per beat of the longest burst
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // One extra bit so a full 16-beat count still fits
    localparam int BEAT_CNT_W = FIFO_AW + 1;

    // Page remap table
    localparam int REMAP_ENTRIES = 16;
    localparam int REMAP_IDX_W = $clog2(REMAP_ENTRIES);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0] axi_id_t;
    typedef logic [LEN_W-1:0] axi_len_t;

    // Address bits 39 to 12
    typedef logic [PAGE_W-1:0] page_t;

    typedef logic [REMAP_IDX_W-1:0] remap_idx_t;
    typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

    // Write pointer and read pointer carry a wrap bit above the index
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    // Address hold FSM
    //   AW_IDLE        waiting for a CPU burst
    //   AW_COLLECT     beats flowing into the FIFO
    //   AW_WAIT_GRANT  all beats stored, asking the engine
    typedef enum logic [1:0] {
        AW_IDLE,
        AW_COLLECT,
        AW_WAIT_GRANT
    } aw_state_t;

endpackage

`default_nettype wire

/* rtl/aw_hold.sv */
`default_nettype none

module aw_hold (
    input  wire                       clk,
    input  wire                       rst,

    input  wire  hawk_pkg::axi_id_t   s_axi_awid,
    input  wire  hawk_pkg::addr_t     s_axi_awaddr,
    input  wire  hawk_pkg::axi_len_t  s_axi_awlen,
    input  wire  [2:0]                s_axi_awsize,
    input  wire  [1:0]                s_axi_awburst,
    input  wire                       s_axi_awvalid,
    output logic                      s_axi_awready,

    input  wire                       beat_accept,
    output logic                      hold,

    output logic                      req_valid,
    output hawk_pkg::page_t           req_page,
    input  wire                       grant,
    input  wire  hawk_pkg::page_t     grant_page,
    input  wire                       hawk_inactive,

    output hawk_pkg::axi_id_t         m_axi_awid,
    output hawk_pkg::addr_t           m_axi_awaddr,
    output hawk_pkg::axi_len_t        m_axi_awlen,
    output logic [2:0]                m_axi_awsize,
    output logic [1:0]                m_axi_awburst,
    output logic                      m_axi_awvalid,
    input  wire                       m_axi_awready
);

    import hawk_pkg::*;

    aw_state_t state;
    beat_cnt_t beat_cnt;
    logic      granted;
    logic      aw_fire;
    logic      last_beat;
    logic      splice;

    assign aw_fire = (state == AW_IDLE) && s_axi_awready && s_axi_awvalid;

    // awlen is the beat count minus one, so compare before the increment
    assign last_beat = beat_accept && (axi_len_t'(beat_cnt) == m_axi_awlen);

    // Engine asked only while it is active
    assign req_valid = (state == AW_WAIT_GRANT) && !hawk_inactive;
    assign req_page = m_axi_awaddr[ADDR_W-1:PAGE_LSB];

    // Take the answer once per request
    assign splice = req_valid && grant && !granted;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= AW_IDLE;
            hold <= 1'b1;
            beat_cnt <= '0;
            granted <= 1'b0;
            s_axi_awready <= 1'b0;
            m_axi_awvalid <= 1'b0;
        end else begin
            if (m_axi_awready) begin
                m_axi_awvalid <= 1'b0;
            end

            case (state)
                AW_IDLE: begin
                    // Only one burst in flight, wait for the previous AW to leave
                    s_axi_awready <= !(m_axi_awvalid && !m_axi_awready);
                    if (aw_fire) begin
                        s_axi_awready <= 1'b0;
                        hold <= 1'b0;
                        beat_cnt <= '0;
                        state <= AW_COLLECT;
                    end
                end
                AW_COLLECT: begin
                    if (beat_accept) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        hold <= 1'b1;
                        state <= AW_WAIT_GRANT;
                    end
                end
                AW_WAIT_GRANT: begin
                    if (hawk_inactive || granted) begin
                        m_axi_awvalid <= 1'b1;
                        granted <= 1'b0;
                        state <= AW_IDLE;
                    end else if (splice) begin
                        granted <= 1'b1;
                    end
                end
                default: state <= AW_IDLE;
            endcase
        end
    end

    // Held burst fields, page bits overwritten by the engine's answer
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            m_axi_awid <= s_axi_awid;
            m_axi_awaddr <= s_axi_awaddr;
            m_axi_awlen <= s_axi_awlen;
            m_axi_awsize <= s_axi_awsize;
            m_axi_awburst <= s_axi_awburst;
        end else if (splice) begin
            m_axi_awaddr[ADDR_W-1:PAGE_LSB] <= grant_page;
        end
    end

endmodule

`default_nettype wire

/* rtl/wdata_fifo.sv */
`default_nettype none

module wdata_fifo (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    hold,

    input  wire  hawk_pkg::data_t  s_axi_wdata,
    input  wire  hawk_pkg::strb_t  s_axi_wstrb,
    input  wire                    s_axi_wlast,
    input  wire                    s_axi_wvalid,
    output logic                   s_axi_wready,
    output logic                   beat_accept,

    output hawk_pkg::data_t        m_axi_wdata,
    output hawk_pkg::strb_t        m_axi_wstrb,
    output logic                   m_axi_wlast,
    output logic                   m_axi_wvalid,
    input  wire                    m_axi_wready
);

    import hawk_pkg::*;

    data_t mem_data [FIFO_DEPTH];
    strb_t mem_strb [FIFO_DEPTH];
    logic  mem_last [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;

    // Memory read stage
    data_t rd_data;
    strb_t rd_strb;
    logic  rd_last;
    logic  rd_valid;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;
    logic store_out;

    // Same index, opposite wrap bit
    assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign s_axi_wready = !full && !hold;
    assign wr_en = s_axi_wvalid && s_axi_wready;
    assign beat_accept = wr_en;

    // Output register free or draining this cycle
    assign store_out = m_axi_wready || !m_axi_wvalid;
    assign rd_en = !empty && (store_out || !rd_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rd_valid <= 1'b0;
            m_axi_wvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (store_out || !rd_valid) begin
                rd_valid <= !empty;
            end
            if (store_out) begin
                m_axi_wvalid <= rd_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[FIFO_AW-1:0]] <= s_axi_wdata;
            mem_strb[wr_ptr[FIFO_AW-1:0]] <= s_axi_wstrb;
            mem_last[wr_ptr[FIFO_AW-1:0]] <= s_axi_wlast;
        end
        if (rd_en) begin
            rd_data <= mem_data[rd_ptr[FIFO_AW-1:0]];
            rd_strb <= mem_strb[rd_ptr[FIFO_AW-1:0]];
            rd_last <= mem_last[rd_ptr[FIFO_AW-1:0]];
        end
        if (store_out) begin
            m_axi_wdata <= rd_data;
            m_axi_wstrb <= rd_strb;
            m_axi_wlast <= rd_last;
        end
    end

endmodule

`default_nettype wire

/* rtl/page_remap.sv */
`default_nettype none

module page_remap (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       req_valid,
    input  wire  hawk_pkg::page_t     req_page,
    output logic                      grant,
    output hawk_pkg::page_t           grant_page,

    input  wire                       cfg_wr,
    input  wire  hawk_pkg::remap_idx_t cfg_idx,
    input  wire  hawk_pkg::page_t     cfg_page,
    input  wire  hawk_pkg::page_t     cfg_ppa
);

    import hawk_pkg::*;

    logic  entry_valid [REMAP_ENTRIES];
    page_t entry_tag [REMAP_ENTRIES];
    page_t entry_ppa [REMAP_ENTRIES];

    logic       req_q;
    logic       req_rise;
    remap_idx_t lookup_idx;

    // Lookup stage
    logic  lookup_valid;
    logic  hit_q;
    page_t ppa_q;
    page_t page_q;

    // Direct mapped on the low page bits
    assign lookup_idx = req_page[REMAP_IDX_W-1:0];
    assign req_rise = req_valid && !req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REMAP_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
            req_q <= 1'b0;
            lookup_valid <= 1'b0;
            grant <= 1'b0;
        end else begin
            if (cfg_wr) begin
                entry_valid[cfg_idx] <= 1'b1;
            end
            req_q <= req_valid;
            lookup_valid <= req_rise;
            grant <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            entry_tag[cfg_idx] <= cfg_page;
            entry_ppa[cfg_idx] <= cfg_ppa;
        end
        if (req_rise) begin
            hit_q <= entry_valid[lookup_idx] && (entry_tag[lookup_idx] == req_page);
            ppa_q <= entry_ppa[lookup_idx];
            page_q <= req_page;
        end
        // Miss answers with the page it was asked about
        if (lookup_valid) begin
            grant_page <= hit_q ? ppa_q : page_q;
        end
    end

endmodule

`default_nettype wire

/* rtl/hawk_stall_wr_top.sv */
`default_nettype none

module hawk_stall_wr_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        hawk_inactive,

    input  wire                        cfg_wr,
    input  wire  hawk_pkg::remap_idx_t cfg_idx,
    input  wire  hawk_pkg::page_t      cfg_page,
    input  wire  hawk_pkg::page_t      cfg_ppa,

    // CPU side, AXI4 slave
    input  wire  hawk_pkg::axi_id_t    s_axi_awid,
    input  wire  hawk_pkg::addr_t      s_axi_awaddr,
    input  wire  hawk_pkg::axi_len_t   s_axi_awlen,
    input  wire  [2:0]                 s_axi_awsize,
    input  wire  [1:0]                 s_axi_awburst,
    input  wire                        s_axi_awvalid,
    output wire                        s_axi_awready,
    input  wire  hawk_pkg::data_t      s_axi_wdata,
    input  wire  hawk_pkg::strb_t      s_axi_wstrb,
    input  wire                        s_axi_wlast,
    input  wire                        s_axi_wvalid,
    output wire                        s_axi_wready,
    output wire  hawk_pkg::axi_id_t    s_axi_bid,
    output wire  [1:0]                 s_axi_bresp,
    output wire                        s_axi_bvalid,
    input  wire                        s_axi_bready,

    // Memory side, AXI4 master
    output wire  hawk_pkg::axi_id_t    m_axi_awid,
    output wire  hawk_pkg::addr_t      m_axi_awaddr,
    output wire  hawk_pkg::axi_len_t   m_axi_awlen,
    output wire  [2:0]                 m_axi_awsize,
    output wire  [1:0]                 m_axi_awburst,
    output wire                        m_axi_awvalid,
    input  wire                        m_axi_awready,
    output wire  hawk_pkg::data_t      m_axi_wdata,
    output wire  hawk_pkg::strb_t      m_axi_wstrb,
    output wire                        m_axi_wlast,
    output wire                        m_axi_wvalid,
    input  wire                        m_axi_wready,
    input  wire  hawk_pkg::axi_id_t    m_axi_bid,
    input  wire  [1:0]                 m_axi_bresp,
    input  wire                        m_axi_bvalid,
    output wire                        m_axi_bready
);

    import hawk_pkg::*;

    wire   hold;
    wire   beat_accept;
    wire   req_valid;
    wire   grant;
    page_t req_page;
    page_t grant_page;

    aw_hold u_aw_hold (
        .clk(clk), .rst(rst),
        .s_axi_awid(s_axi_awid), .s_axi_awaddr(s_axi_awaddr), .s_axi_awlen(s_axi_awlen),
        .s_axi_awsize(s_axi_awsize), .s_axi_awburst(s_axi_awburst),
        .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
        .beat_accept(beat_accept), .hold(hold),
        .req_valid(req_valid), .req_page(req_page),
        .grant(grant), .grant_page(grant_page), .hawk_inactive(hawk_inactive),
        .m_axi_awid(m_axi_awid), .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
        .m_axi_awsize(m_axi_awsize), .m_axi_awburst(m_axi_awburst),
        .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready)
    );

    page_remap u_page_remap (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_page(req_page),
        .grant(grant), .grant_page(grant_page),
        .cfg_wr(cfg_wr), .cfg_idx(cfg_idx), .cfg_page(cfg_page), .cfg_ppa(cfg_ppa)
    );

    wdata_fifo u_wdata_fifo (
        .clk(clk), .rst(rst), .hold(hold),
        .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb), .s_axi_wlast(s_axi_wlast),
        .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
        .beat_accept(beat_accept),
        .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb), .m_axi_wlast(m_axi_wlast),
        .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready)
    );

    // Write response goes straight through
    assign s_axi_bid = m_axi_bid;
    assign s_axi_bresp = m_axi_bresp;
    assign s_axi_bvalid = m_axi_bvalid;
    assign m_axi_bready = s_axi_bready;

endmodule

`default_nettype wire

/* verif/tb_axi_mem_sink.sv */
`default_nettype none

module tb_axi_mem_sink (
    input  wire                       clk,

    input  wire  hawk_pkg::axi_id_t   m_axi_awid,
    input  wire  hawk_pkg::addr_t     m_axi_awaddr,
    input  wire  hawk_pkg::axi_len_t  m_axi_awlen,
    input  wire  [2:0]                m_axi_awsize,
    input  wire  [1:0]                m_axi_awburst,
    input  wire                       m_axi_awvalid,
    output logic                      m_axi_awready,

    input  wire  hawk_pkg::data_t     m_axi_wdata,
    input  wire  hawk_pkg::strb_t     m_axi_wstrb,
    input  wire                       m_axi_wlast,
    input  wire                       m_axi_wvalid,
    output logic                      m_axi_wready,

    output hawk_pkg::axi_id_t         m_axi_bid,
    output logic [1:0]                m_axi_bresp,
    output logic                      m_axi_bvalid,
    input  wire                       m_axi_bready
);

    import hawk_pkg::*;

    // Recorded traffic, popped by the testbench top
    axi_id_t  aw_id_q [$];
    addr_t    aw_addr_q [$];
    axi_len_t aw_len_q [$];
    logic [2:0] aw_size_q [$];
    logic [1:0] aw_burst_q [$];
    data_t    w_data_q [$];
    strb_t    w_strb_q [$];
    logic     w_last_q [$];

    axi_id_t  b_pending_q [$];
    int       wlast_cnt;
    logic     b_taken;
    logic [31:0] lfsr;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        lfsr = 32'h3f32d069;
        wlast_cnt = 0;
        b_taken = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        m_axi_bvalid = 1'b0;
        m_axi_bid = '0;
        m_axi_bresp = 2'b00;
    end

    always @(posedge clk) begin
        if (m_axi_awvalid && m_axi_awready) begin
            aw_id_q.push_back(m_axi_awid);
            aw_addr_q.push_back(m_axi_awaddr);
            aw_len_q.push_back(m_axi_awlen);
            aw_size_q.push_back(m_axi_awsize);
            aw_burst_q.push_back(m_axi_awburst);
            b_pending_q.push_back(m_axi_awid);
        end
        if (m_axi_wvalid && m_axi_wready) begin
            w_data_q.push_back(m_axi_wdata);
            w_strb_q.push_back(m_axi_wstrb);
            w_last_q.push_back(m_axi_wlast);
            if (m_axi_wlast) begin
                wlast_cnt++;
            end
        end
        if (m_axi_bvalid && m_axi_bready) begin
            b_taken = 1'b1;
        end
    end

    // Back-pressure and responses change on the falling edge
    always @(negedge clk) begin
        lfsr = lfsr_step(lfsr);
        m_axi_awready = lfsr[0];
        lfsr = lfsr_step(lfsr);
        m_axi_wready = lfsr[0];
        if (b_taken) begin
            m_axi_bvalid = 1'b0;
            b_taken = 1'b0;
        end
        // B only once both the address and the last beat are in
        if (!m_axi_bvalid && b_pending_q.size() > 0 && wlast_cnt > 0) begin
            m_axi_bid = b_pending_q.pop_front();
            m_axi_bresp = m_axi_bid[1:0];
            m_axi_bvalid = 1'b1;
            wlast_cnt--;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_hawk_stall_wr.sv */
`default_nettype none

module tb_hawk_stall_wr;

    import hawk_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int NUM_CFG = 4;

    logic clk;
    logic rst;
    logic hawk_inactive;
    logic cfg_wr;
    remap_idx_t cfg_idx;
    page_t cfg_page;
    page_t cfg_ppa;

    axi_id_t s_axi_awid;
    addr_t s_axi_awaddr;
    axi_len_t s_axi_awlen;
    logic [2:0] s_axi_awsize;
    logic [1:0] s_axi_awburst;
    logic s_axi_awvalid;
    wire s_axi_awready;
    data_t s_axi_wdata;
    strb_t s_axi_wstrb;
    logic s_axi_wlast;
    logic s_axi_wvalid;
    wire s_axi_wready;
    axi_id_t s_axi_bid;
    wire [1:0] s_axi_bresp;
    wire s_axi_bvalid;
    logic s_axi_bready;

    axi_id_t m_axi_awid;
    addr_t m_axi_awaddr;
    axi_len_t m_axi_awlen;
    wire [2:0] m_axi_awsize;
    wire [1:0] m_axi_awburst;
    wire m_axi_awvalid;
    wire m_axi_awready;
    data_t m_axi_wdata;
    strb_t m_axi_wstrb;
    wire m_axi_wlast;
    wire m_axi_wvalid;
    wire m_axi_wready;
    axi_id_t m_axi_bid;
    wire [1:0] m_axi_bresp;
    wire m_axi_bvalid;
    wire m_axi_bready;

    // Burst table
    axi_id_t row_id [NUM_ROWS];
    addr_t row_addr [NUM_ROWS];
    axi_len_t row_len [NUM_ROWS];
    logic row_inactive [NUM_ROWS];
    data_t row_seed [NUM_ROWS];

    // Remap entries written at start
    page_t tbl_page [NUM_CFG];
    page_t tbl_ppa [NUM_CFG];

    int errors;
    logic stalled;

    hawk_stall_wr_top u_hawk_stall_wr_top (.*);

    tb_axi_mem_sink u_sink (
        .clk(clk),
        .m_axi_awid(m_axi_awid), .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
        .m_axi_awsize(m_axi_awsize), .m_axi_awburst(m_axi_awburst),
        .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
        .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb), .m_axi_wlast(m_axi_wlast),
        .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
        .m_axi_bid(m_axi_bid), .m_axi_bresp(m_axi_bresp),
        .m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(NUM_ROWS * 200 * 100);
        $display("Timeout: bursts did not complete in time");
        $display("FAIL: see errors above");
        $finish;
    end

    // Entries at index 1, 2, 7 and 10
    task automatic fill_tables();
        tbl_page = '{28'h00a0011, 28'h0123452, 28'h0042007, 28'h0aaaaaa};
        tbl_ppa = '{28'h7770055, 28'h0fedcb0, 28'h0001007, 28'h5555555};
        row_id = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hb};
        row_addr = '{40'h00a0011100, 40'h0123452040, 40'h0999991010, 40'h0042007800,
                     40'h0aaaaaa000, 40'h0111112200, 40'h00a0011ff0, 40'h0042007010};
        row_len = '{8'd3, 8'd15, 8'd0, 8'd7, 8'd12, 8'd5, 8'd1, 8'd10};
        row_inactive = '{0, 0, 0, 1, 0, 0, 1, 0};
        row_seed = '{64'h1000_0000_0000_00a5, 64'h2222_3333_4444_5500,
                     64'h0badc0de_0000_0081, 64'hffff_0000_ffff_0f0f,
                     64'h0123_4567_89ab_cd33, 64'hdead_beef_0000_0001,
                     64'h5a5a_5a5a_5a5a_5af0, 64'h0000_0000_0000_00c3};
    endtask

    // Remap rule applied to the programmed entries
    function automatic addr_t expected_addr(input int r);
        page_t pg;
        addr_t result;
        pg = row_addr[r][ADDR_W-1:PAGE_LSB];
        result = row_addr[r];
        if (!row_inactive[r]) begin
            for (int i = 0; i < NUM_CFG; i++) begin
                if (tbl_page[i][3:0] == pg[3:0] && tbl_page[i] == pg) begin
                    result = {tbl_ppa[i], row_addr[r][PAGE_LSB-1:0]};
                end
            end
        end
        return result;
    endfunction

    function automatic strb_t beat_strb(input data_t seed, input int beat);
        strb_t s;
        s = seed[7:0];
        for (int i = 0; i < beat % 8; i++) begin
            s = {s[6:0], s[7]};
        end
        return s;
    endfunction

    task automatic send_aw(input int r);
        // Beats go out first and must wait for the address
        repeat (3) @(negedge clk);
        s_axi_awid = row_id[r];
        s_axi_awaddr = row_addr[r];
        s_axi_awlen = row_len[r];
        s_axi_awsize = 3'd3;
        s_axi_awburst = 2'b01;
        s_axi_awvalid = 1'b1;
        do @(posedge clk); while (!s_axi_awready);
        @(negedge clk);
        s_axi_awvalid = 1'b0;
    endtask

    task automatic send_beats(input int r);
        for (int b = 0; b <= row_len[r]; b++) begin
            @(negedge clk);
            s_axi_wdata = row_seed[r] + b;
            s_axi_wstrb = beat_strb(row_seed[r], b);
            s_axi_wlast = (b == row_len[r]);
            s_axi_wvalid = 1'b1;
            do @(posedge clk); while (!s_axi_wready);
        end
        @(negedge clk);
        s_axi_wvalid = 1'b0;
        s_axi_wlast = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_burst(input int r);
        data_t d;
        strb_t s;
        logic l;
        if (u_sink.aw_addr_q.size() != 1) begin
            $display("Row %0d: expected one recorded AW, found %0d", r,
                     u_sink.aw_addr_q.size());
            errors++;
            return;
        end
        check_value("m_axi_awaddr", u_sink.aw_addr_q.pop_front(), expected_addr(r));
        check_value("m_axi_awid", u_sink.aw_id_q.pop_front(), row_id[r]);
        check_value("m_axi_awlen", u_sink.aw_len_q.pop_front(), row_len[r]);
        check_value("m_axi_awsize", u_sink.aw_size_q.pop_front(), 3'd3);
        check_value("m_axi_awburst", u_sink.aw_burst_q.pop_front(), 2'b01);
        if (u_sink.w_data_q.size() != row_len[r] + 1) begin
            $display("Row %0d: expected %0d W beats, found %0d", r, row_len[r] + 1,
                     u_sink.w_data_q.size());
            errors++;
            return;
        end
        for (int b = 0; b <= row_len[r]; b++) begin
            d = u_sink.w_data_q.pop_front();
            s = u_sink.w_strb_q.pop_front();
            l = u_sink.w_last_q.pop_front();
            check_value("m_axi_wdata", d, row_seed[r] + b);
            check_value("m_axi_wstrb", s, beat_strb(row_seed[r], b));
            check_value("m_axi_wlast", l, b == row_len[r]);
        end
    endtask

    // No CPU beat may enter between a burst's last beat and the next AW
    always @(posedge clk) begin
        if (rst) begin
            stalled <= 1'b0;
        end else begin
            if (stalled && s_axi_wready) begin
                $display("CHECK FAILED s_axi_wready: got %h expected %h", 1'b1, 1'b0);
                errors++;
            end
            if (s_axi_wvalid && s_axi_wready && s_axi_wlast) begin
                stalled <= 1'b1;
            end else if (s_axi_awvalid && s_axi_awready) begin
                stalled <= 1'b0;
            end
        end
    end

    initial begin
        errors = 0;
        rst = 1'b1;
        hawk_inactive = 1'b0;
        cfg_wr = 1'b0;
        cfg_idx = '0;
        cfg_page = '0;
        cfg_ppa = '0;
        s_axi_awid = '0;
        s_axi_awaddr = '0;
        s_axi_awlen = '0;
        s_axi_awsize = '0;
        s_axi_awburst = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_wlast = 1'b0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b1;
        fill_tables();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_CFG; i++) begin
            @(negedge clk);
            cfg_wr = 1'b1;
            cfg_idx = tbl_page[i][3:0];
            cfg_page = tbl_page[i];
            cfg_ppa = tbl_ppa[i];
        end
        @(negedge clk);
        cfg_wr = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            hawk_inactive = row_inactive[r];
            s_axi_bready = 1'b0;
            fork
                send_aw(r);
                send_beats(r);
            join
            // Sink holds the response until the CPU side is ready
            do @(posedge clk); while (!s_axi_bvalid);
            check_value("m_axi_bready", m_axi_bready, 1'b0);
            @(negedge clk);
            s_axi_bready = 1'b1;
            do @(posedge clk); while (!(s_axi_bvalid && s_axi_bready));
            check_value("m_axi_bready", m_axi_bready, 1'b1);
            check_value("s_axi_bid", s_axi_bid, m_axi_bid);
            check_value("s_axi_bresp", s_axi_bresp, m_axi_bresp);
            check_value("s_axi_bid", s_axi_bid, row_id[r]);
            check_value("s_axi_bresp", s_axi_bresp, row_id[r][1:0]);
            check_burst(r);
        end

        repeat (4) @(posedge clk);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/hawk_pkg.sv
rtl/aw_hold.sv
rtl/wdata_fifo.sv
rtl/page_remap.sv
rtl/hawk_stall_wr_top.sv
verif/tb_axi_mem_sink.sv
verif/tb_hawk_stall_wr.sv
